// ==== src/ntm_types_pkg.sv ====
package ntm_types_pkg;

  ////////////////////
  // Data words
  ////////////////////

  // Stored vector and weight element
  typedef logic signed [15:0] data_t;

  // Products and sums wrap here
  typedef logic signed [31:0] acc_t;

  ////////////////////
  // Vector sizes
  ////////////////////

  localparam int unsigned SIZE_X = 4;
  localparam int unsigned SIZE_L = 4;
  localparam int unsigned SIZE_Y = 4;

  typedef logic [$clog2(SIZE_X)-1:0] x_idx_t;
  typedef logic [$clog2(SIZE_L)-1:0] l_idx_t;

  // Covers W, b and U in one flat space
  typedef logic [5:0] weight_addr_t;

endpackage

// ==== src/ntm_ctrl_pkg.sv ====
package ntm_ctrl_pkg;

  // Sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_CAPTURE,
    ST_HIDDEN_ROW,
    ST_OUTPUT_ROW,
    ST_EMIT
  } seq_state_t;

  // Accumulator operations
  typedef enum logic [1:0] {
    MAC_NONE,
    MAC_CLEAR,
    MAC_MAC,
    MAC_ADD_BIAS
  } mac_op_t;

  // Load order is W rows, then b, then U rows
  localparam int unsigned W_BASE     = 0;
  localparam int unsigned B_BASE     = 16;
  localparam int unsigned U_BASE     = 20;
  localparam int unsigned LOAD_WORDS = 36;

endpackage

// ==== src/ntm_mac_if.sv ====
`timescale 1ns/1ns

interface ntm_mac_if
  import ntm_types_pkg::*;
  import ntm_ctrl_pkg::*;
();

  mac_op_t op;
  data_t   coef;
  data_t   operand;
  data_t   bias;
  data_t   result;

  // Sequencer issues the operation and collects the result
  modport seq (output op, input result);

  // Weight store supplies the coefficient and the row bias
  modport store (output coef, output bias);

  // Vector buffer supplies the x or h element
  modport vbuf (output operand);

  modport mac (
    input  op,
    input  coef,
    input  operand,
    input  bias,
    output result
  );

endinterface

// ==== src/ntm_weight_store.sv ====
`timescale 1ns/1ns

module ntm_weight_store
  import ntm_types_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         wr_en,
  input  weight_addr_t wr_addr,
  input  data_t        wr_data,
  input  weight_addr_t rd_addr,
  ntm_mac_if.store     mac
);

  data_t        mem [LOAD_WORDS];
  weight_addr_t bias_addr;

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < LOAD_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en && (wr_addr < LOAD_WORDS)) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // Addresses past the U region read as zero
  assign mac.coef = (rd_addr < LOAD_WORDS) ? mem[rd_addr] : '0;

  // Row of a W address selects its bias
  assign bias_addr = weight_addr_t'(B_BASE) + weight_addr_t'(rd_addr[3:2]);
  assign mac.bias  = mem[bias_addr];

endmodule

// ==== src/ntm_mac_unit.sv ====
`timescale 1ns/1ns

module ntm_mac_unit
  import ntm_types_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  ntm_mac_if.mac mac
);

  acc_t acc;
  acc_t product;

  // Both operands sign extend first, so the product wraps in 32 bits
  assign product = acc_t'(mac.coef) * acc_t'(mac.operand);

  ////////////////////
  // Accumulator
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
    end else begin
      case (mac.op)
        MAC_CLEAR: begin
          acc <= '0;
        end
        MAC_MAC: begin
          acc <= acc + product;
        end
        MAC_ADD_BIAS: begin
          acc <= acc + acc_t'(mac.bias);
        end
        default: begin
          // Hold for the sequencer to pick up
          acc <= acc;
        end
      endcase
    end
  end

  // Stored elements keep the low half only
  assign mac.result = data_t'(acc[15:0]);

endmodule

// ==== src/ntm_vector_buffer.sv ====
`timescale 1ns/1ns

module ntm_vector_buffer
  import ntm_types_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  logic    x_wr,
  input  x_idx_t  x_wr_idx,
  input  data_t   x_data,
  input  logic    h_wr,
  input  l_idx_t  h_wr_idx,
  input  data_t   h_data,
  input  logic    sel_h,
  input  x_idx_t  op_idx,
  ntm_mac_if.vbuf mac
);

  data_t x_vec [SIZE_X];
  data_t h_vec [SIZE_L];

  ////////////////////
  // Vector storage
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < SIZE_X; i++) begin
        x_vec[i] <= '0;
      end
      for (int i = 0; i < SIZE_L; i++) begin
        h_vec[i] <= '0;
      end
    end else begin
      if (x_wr) begin
        x_vec[x_wr_idx] <= x_data;
      end
      if (h_wr) begin
        h_vec[h_wr_idx] <= h_data;
      end
    end
  end

  // x feeds the hidden step, h feeds the output step
  assign mac.operand = sel_h ? h_vec[l_idx_t'(op_idx)] : x_vec[op_idx];

endmodule

// ==== src/ntm_sequencer.sv ====
`timescale 1ns/1ns

module ntm_sequencer
  import ntm_types_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         load_valid,
  output logic         load_ready,
  input  data_t        load_data,
  input  logic         x_valid,
  output logic         x_ready,
  output logic         y_valid,
  input  logic         y_ready,
  output data_t        y_data,
  ntm_mac_if.seq       mac,
  output logic         wr_en,
  output weight_addr_t wr_addr,
  output data_t        wr_data,
  output weight_addr_t rd_addr,
  output logic         x_wr,
  output x_idx_t       x_wr_idx,
  output logic         h_wr,
  output l_idx_t       h_wr_idx,
  output logic         sel_h,
  output x_idx_t       op_idx
);

  seq_state_t                  state;
  weight_addr_t                load_ptr;
  logic                        weights_ok;
  x_idx_t                      x_cnt;
  l_idx_t                      row;
  logic [2:0]                  step;
  x_idx_t                      col;
  logic [$clog2(SIZE_Y)-1:0]   out_idx;
  logic [$clog2(SIZE_Y)-1:0]   y_slot;
  logic                        y_pend;
  data_t                       y_reg [SIZE_Y];
  logic                        load_xfer;
  logic                        x_xfer;
  logic                        y_xfer;

  ////////////////////
  // Stream handshakes
  ////////////////////

  always_comb begin
    load_ready = 1'b0;
    x_ready    = 1'b0;
    case (state)
      ST_IDLE: begin
        // A waiting load word wins over a new input vector
        load_ready = load_valid || !weights_ok;
        x_ready    = weights_ok && !load_valid;
      end
      ST_LOAD:    load_ready = 1'b1;
      ST_CAPTURE: x_ready = 1'b1;
      default: ;
    endcase
  end

  assign y_valid   = (state == ST_EMIT);
  assign y_data    = y_reg[out_idx];
  assign load_xfer = load_valid && load_ready;
  assign x_xfer    = x_valid && x_ready;
  assign y_xfer    = y_valid && y_ready;

  assign wr_en    = load_xfer;
  assign wr_addr  = load_ptr;
  assign wr_data  = load_data;
  assign x_wr     = x_xfer;
  assign x_wr_idx = x_cnt;

  ////////////////////
  // Datapath control
  ////////////////////

  // Step 0 clears, steps 1 to 4 walk the columns
  assign col      = x_idx_t'(step - 3'd1);
  assign op_idx   = col;
  assign sel_h    = (state == ST_OUTPUT_ROW);
  assign h_wr     = (state == ST_HIDDEN_ROW) && (step == 3'd6);
  assign h_wr_idx = row;

  always_comb begin
    mac.op  = MAC_NONE;
    rd_addr = weight_addr_t'(W_BASE);
    case (state)
      ST_HIDDEN_ROW: begin
        // Row bits stay put so the store can pick the bias
        rd_addr = weight_addr_t'(W_BASE) + weight_addr_t'({row, col});
        if (step == 3'd0) begin
          mac.op = MAC_CLEAR;
        end else if (step <= 3'd4) begin
          mac.op = MAC_MAC;
        end else if (step == 3'd5) begin
          mac.op = MAC_ADD_BIAS;
        end
      end
      ST_OUTPUT_ROW: begin
        rd_addr = weight_addr_t'(U_BASE) + weight_addr_t'({row, col});
        mac.op  = (step == 3'd0) ? MAC_CLEAR : MAC_MAC;
      end
      default: ;
    endcase
  end

  ////////////////////
  // State machine
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ST_IDLE;
      load_ptr   <= '0;
      weights_ok <= 1'b0;
      x_cnt      <= '0;
      row        <= '0;
      step       <= '0;
      out_idx    <= '0;
      y_slot     <= '0;
      y_pend     <= 1'b0;
    end else begin
      y_pend <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (load_xfer) begin
            // New load invalidates the old weights
            weights_ok <= 1'b0;
            load_ptr   <= load_ptr + 1'b1;
            state      <= ST_LOAD;
          end else if (x_xfer) begin
            x_cnt <= x_cnt + 1'b1;
            state <= ST_CAPTURE;
          end
        end
        ST_LOAD: begin
          if (load_xfer) begin
            if (load_ptr == weight_addr_t'(LOAD_WORDS - 1)) begin
              load_ptr   <= '0;
              weights_ok <= 1'b1;
              state      <= ST_IDLE;
            end else begin
              load_ptr <= load_ptr + 1'b1;
            end
          end
        end
        ST_CAPTURE: begin
          if (x_xfer) begin
            x_cnt <= x_cnt + 1'b1;
            if (x_cnt == x_idx_t'(SIZE_X - 1)) begin
              state <= ST_HIDDEN_ROW;
            end
          end
        end
        ST_HIDDEN_ROW: begin
          // Clear, four MACs, bias, write back
          if (step == 3'd6) begin
            step <= '0;
            row  <= row + 1'b1;
            if (row == l_idx_t'(SIZE_L - 1)) begin
              state <= ST_OUTPUT_ROW;
            end
          end else begin
            step <= step + 1'b1;
          end
        end
        ST_OUTPUT_ROW: begin
          if (step == 3'd4) begin
            step   <= '0;
            row    <= row + 1'b1;
            y_pend <= 1'b1;
            y_slot <= row;
            if (row == l_idx_t'(SIZE_Y - 1)) begin
              state <= ST_EMIT;
            end
          end else begin
            step <= step + 1'b1;
          end
        end
        ST_EMIT: begin
          if (y_xfer) begin
            out_idx <= out_idx + 1'b1;
            if (out_idx == SIZE_Y - 1) begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Finished y lands one cycle after its last MAC
  always_ff @(posedge CLK) begin
    if (y_pend) begin
      y_reg[y_slot] <= mac.result;
    end
  end

endmodule

// ==== src/ntm_top.sv ====
`timescale 1ns/1ns

module ntm_top
  import ntm_types_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  input  logic  load_valid,
  output logic  load_ready,
  input  data_t load_data,

  input  logic  x_valid,
  output logic  x_ready,
  input  data_t x_data,

  output logic  y_valid,
  input  logic  y_ready,
  output data_t y_data
);

  ////////////////////
  // Internal wiring
  ////////////////////

  ntm_mac_if mac_bus ();

  // Weight store write and read
  logic         wr_en;
  weight_addr_t wr_addr;
  data_t        wr_data;
  weight_addr_t rd_addr;

  // Vector buffer control
  logic   x_wr;
  x_idx_t x_wr_idx;
  logic   h_wr;
  l_idx_t h_wr_idx;
  logic   sel_h;
  x_idx_t op_idx;

  ////////////////////
  // Instances
  ////////////////////

  ntm_sequencer ntm_sequencer_i (
    .CLK       (CLK),
    .RST       (RST),
    .load_valid(load_valid),
    .load_ready(load_ready),
    .load_data (load_data),
    .x_valid   (x_valid),
    .x_ready   (x_ready),
    .y_valid   (y_valid),
    .y_ready   (y_ready),
    .y_data    (y_data),
    .mac       (mac_bus.seq),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr),
    .x_wr      (x_wr),
    .x_wr_idx  (x_wr_idx),
    .h_wr      (h_wr),
    .h_wr_idx  (h_wr_idx),
    .sel_h     (sel_h),
    .op_idx    (op_idx)
  );

  ntm_weight_store ntm_weight_store_i (
    .CLK    (CLK),
    .RST    (RST),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .mac    (mac_bus.store)
  );

  ntm_mac_unit ntm_mac_unit_i (
    .CLK(CLK),
    .RST(RST),
    .mac(mac_bus.mac)
  );

  // Hidden results go straight from the accumulator into the buffer
  ntm_vector_buffer ntm_vector_buffer_i (
    .CLK     (CLK),
    .RST     (RST),
    .x_wr    (x_wr),
    .x_wr_idx(x_wr_idx),
    .x_data  (x_data),
    .h_wr    (h_wr),
    .h_wr_idx(h_wr_idx),
    .h_data  (mac_bus.result),
    .sel_h   (sel_h),
    .op_idx  (op_idx),
    .mac     (mac_bus.vbuf)
  );

endmodule

// ==== dv/ntm_top_properties.sv ====
`timescale 1ns/1ns

module ntm_top_properties
  import ntm_types_pkg::*;
(
  input logic  CLK,
  input logic  RST,
  input logic  load_valid,
  input logic  load_ready,
  input data_t load_data,
  input logic  x_valid,
  input logic  x_ready,
  input data_t x_data,
  input logic  y_valid,
  input logic  y_ready,
  input data_t y_data
);

  ////////////////////
  // Stream handshakes
  ////////////////////

  // A word that is not taken stays on the bus unchanged
  load_hold_a: assert property (@(posedge CLK) disable iff (RST)
    load_valid && !load_ready |=> load_valid && $stable(load_data))
    else $error("load word withdrawn or changed before load_ready");

  x_hold_a: assert property (@(posedge CLK) disable iff (RST)
    x_valid && !x_ready |=> x_valid && $stable(x_data))
    else $error("x word withdrawn or changed before x_ready");

  y_hold_a: assert property (@(posedge CLK) disable iff (RST)
    y_valid && !y_ready |=> y_valid && $stable(y_data))
    else $error("y word withdrawn or changed before y_ready");

  // Load and input streams never open together
  ready_excl_a: assert property (@(posedge CLK) disable iff (RST)
    !(load_ready && x_ready))
    else $error("load_ready and x_ready high in the same cycle");

  reset_quiet_a: assert property (@(posedge CLK)
    RST |-> !x_ready && !y_valid)
    else $error("x_ready or y_valid high during reset");

endmodule

bind ntm_top ntm_top_properties ntm_top_properties_i (.*);

// ==== dv/ntm_top_tb.sv ====
`timescale 1ns/1ns

module ntm_top_tb
  import ntm_types_pkg::*;
  import ntm_ctrl_pkg::*;
();

  localparam int CLK_NS  = 4;
  localparam int SEED    = 75044;
  localparam int VECTORS = 28;
  // Load, input, compute and a back-pressure allowance per vector
  localparam int VECTOR_CYCLES = LOAD_WORDS + SIZE_X + 24 + SIZE_Y * 16;
  localparam int WATCHDOG_NS   = 2 * VECTORS * VECTOR_CYCLES * CLK_NS + 8 * CLK_NS;

  logic  CLK;
  logic  RST;
  logic  load_valid;
  logic  load_ready;
  data_t load_data;
  logic  x_valid;
  logic  x_ready;
  data_t x_data;
  logic  y_valid;
  logic  y_ready;
  data_t y_data;

  data_t w_mem [SIZE_L * SIZE_X];
  data_t b_mem [SIZE_L];
  data_t u_mem [SIZE_Y * SIZE_L];
  data_t x_cur [SIZE_X];
  data_t exp_q [$];
  data_t exp_word;
  string test_name;
  int    checks;
  int    errors;
  int    test_checks;
  int    test_errors;
  logic  bp_en;
  int    seed = SEED;
  int    ready_seed = SEED;

  ntm_top ntm_top_i (.*);

  always #(CLK_NS / 2) CLK = ~CLK;

  ////////////////////
  // Reference model
  ////////////////////

  // h = W.x + b, then y = U.h, 32-bit wrap and 16-bit elements
  function automatic data_t ntm_ref(input int k);
    acc_t  sum;
    data_t h [SIZE_L];
    for (int i = 0; i < SIZE_L; i++) begin
      sum = '0;
      for (int j = 0; j < SIZE_X; j++) begin
        sum = sum + acc_t'(w_mem[i * SIZE_X + j]) * acc_t'(x_cur[j]);
      end
      sum  = sum + acc_t'(b_mem[i]);
      h[i] = sum[15:0];
    end
    sum = '0;
    for (int j = 0; j < SIZE_L; j++) begin
      sum = sum + acc_t'(u_mem[k * SIZE_L + j]) * acc_t'(h[j]);
    end
    return sum[15:0];
  endfunction

  // Kind 0 small, 1 any word, 2 near full scale
  function automatic data_t pick_value(input int kind);
    data_t v;
    v = data_t'($random(seed));
    if (kind == 0) begin
      v = data_t'($random(seed) % 128);
    end else if (kind == 2) begin
      v[14:12] = v[15] ? 3'b000 : 3'b111;
    end
    return v;
  endfunction

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic put_weight(input data_t word);
    load_valid = 1'b1;
    load_data  = word;
    @(posedge CLK);
    while (!load_ready) begin
      @(posedge CLK);
    end
    if (x_ready) begin
      $display("Error: x_ready was high while a load word was offered in test %s", test_name);
      errors++;
    end
    @(negedge CLK);
  endtask

  task automatic load_weights();
    for (int i = 0; i < SIZE_L * SIZE_X; i++) begin
      put_weight(w_mem[i]);
    end
    for (int i = 0; i < SIZE_L; i++) begin
      put_weight(b_mem[i]);
    end
    for (int i = 0; i < SIZE_Y * SIZE_L; i++) begin
      put_weight(u_mem[i]);
    end
    load_valid = 1'b0;
    load_data  = '0;
    @(posedge CLK);
    if (!x_ready) begin
      $display("Error: x_ready stayed low after the weight load in test %s", test_name);
      errors++;
    end
    @(negedge CLK);
  endtask

  task automatic fill_weights(input int kind);
    for (int i = 0; i < SIZE_L * SIZE_X; i++) begin
      w_mem[i] = pick_value(kind);
    end
    for (int i = 0; i < SIZE_L; i++) begin
      b_mem[i] = pick_value(kind);
    end
    for (int i = 0; i < SIZE_Y * SIZE_L; i++) begin
      u_mem[i] = pick_value(kind);
    end
  endtask

  // Sends x_cur and waits until its four y words are checked
  task automatic run_vector(input int kind, input bit identity);
    for (int j = 0; j < SIZE_X; j++) begin
      x_cur[j] = pick_value(kind);
    end
    for (int k = 0; k < SIZE_Y; k++) begin
      exp_q.push_back(identity ? x_cur[k] : ntm_ref(k));
    end
    for (int j = 0; j < SIZE_X; j++) begin
      x_valid = 1'b1;
      x_data  = x_cur[j];
      @(posedge CLK);
      while (!x_ready) begin
        @(posedge CLK);
      end
      @(negedge CLK);
    end
    x_valid = 1'b0;
    x_data  = '0;
    while (exp_q.size() != 0) begin
      @(negedge CLK);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test();
    if (y_valid) begin
      $display("Error: y_valid still high after the last word of test %s", test_name);
      errors++;
    end
    $display("Test %s done: %0d words checked, %0d errors", test_name,
             checks - test_checks, errors - test_errors);
  endtask

  ////////////////////
  // Output check
  ////////////////////

  always @(posedge CLK) begin
    if (!RST && y_valid && y_ready) begin
      if (exp_q.size() == 0) begin
        $display("Error: y word %0d arrived with no result pending in test %s",
                 y_data, test_name);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        checks++;
        if (y_data !== exp_word) begin
          $display("Fail %s: expected %0d, actual %0d", test_name, exp_word, y_data);
          errors++;
        end
      end
    end
  end

  // Random stalls on the output stream
  always @(negedge CLK) begin
    if (bp_en) begin
      y_ready = ($random(ready_seed) & 1) != 0;
    end else begin
      y_ready = 1'b1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Error: run did not finish within %0d ns in test %s", WATCHDOG_NS, test_name);
    $display("Tests stopped: %0d words checked, %0d errors", checks, errors + 1);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    CLK        = 1'b0;
    RST        = 1'b1;
    load_valid = 1'b0;
    load_data  = '0;
    x_valid    = 1'b0;
    x_data     = '0;
    y_ready    = 1'b1;
    bp_en      = 1'b0;
    checks     = 0;
    errors     = 0;
    test_name  = "reset_state";
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    start_test("reset_state");
    if (x_ready || y_valid || !load_ready) begin
      $display("Error: after reset expected load_ready high, x_ready and y_valid low");
      errors++;
    end
    end_test();

    // Unit diagonal in W and U, zero bias
    start_test("identity");
    for (int i = 0; i < SIZE_L; i++) begin
      b_mem[i] = '0;
      for (int j = 0; j < SIZE_X; j++) begin
        w_mem[i * SIZE_X + j] = (i == j) ? 16'sd1 : 16'sd0;
        u_mem[i * SIZE_L + j] = (i == j) ? 16'sd1 : 16'sd0;
      end
    end
    load_weights();
    repeat (4) run_vector(1, 1'b1);
    end_test();

    start_test("random");
    fill_weights(0);
    load_weights();
    repeat (8) run_vector(1, 1'b0);
    end_test();

    start_test("backpressure");
    bp_en = 1'b1;
    repeat (8) run_vector(1, 1'b0);
    bp_en = 1'b0;
    end_test();

    start_test("reload");
    fill_weights(1);
    load_weights();
    repeat (4) run_vector(1, 1'b0);
    end_test();

    // Near full scale operands force both wraps
    start_test("wrap");
    fill_weights(2);
    load_weights();
    repeat (4) run_vector(2, 1'b0);
    end_test();

    $display("Tests done: %0d words checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== ntm_top.f ====
src/ntm_types_pkg.sv
src/ntm_ctrl_pkg.sv
src/ntm_mac_if.sv
src/ntm_weight_store.sv
src/ntm_mac_unit.sv
src/ntm_vector_buffer.sv
src/ntm_sequencer.sv
src/ntm_top.sv
dv/ntm_top_properties.sv
dv/ntm_top_tb.sv
